// ==== sources.f ====
design/cache_pkg.sv
design/cache_decode.sv
design/cache_arrays.sv
design/cache_result.sv
design/cache_mem_top.sv
test/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the cache testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module cache_tb -f sources.f -o cache_sim \
  && ./obj_dir/cache_sim | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "cache simulation passed" \
  || { echo "cache simulation failed"; exit 1; }

// ==== test/cache_tb.sv ====
// cache memory testbench
// table of requests and expected responses, issued back to back
// random response back-pressure, in-order checking of every response

`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int N_ENTRIES  = 25;
  localparam int SEED_INIT  = 84656;

  // tags and lines used by the table
  localparam logic [TAG_BITS-1:0] TAG_A = 9'h011;
  localparam logic [TAG_BITS-1:0] TAG_B = 9'h0A0;
  localparam logic [TAG_BITS-1:0] TAG_C = 9'h055;  // never installed
  localparam logic [TAG_BITS-1:0] TAG_D = 9'h033;
  localparam logic [TAG_BITS-1:0] TAG_E = 9'h044;
  localparam logic [TAG_BITS-1:0] TAG_F = 9'h077;
  localparam logic [TAG_BITS-1:0] TAG_G = 9'h1FF;

  localparam logic [BLK_BITS-1:0] LINE_A   = 128'h11112222_33334444_55556666_77778888;
  // word 1 of LINE_A with bytes 0 and 2 taken from 32'hAABBCCDD
  localparam logic [BLK_BITS-1:0] LINE_A_M = 128'h11112222_33334444_55BB66DD_77778888;
  localparam logic [BLK_BITS-1:0] LINE_B   = 128'hA0A0A0A0_B1B1B1B1_C2C2C2C2_D3D3D3D3;
  localparam logic [BLK_BITS-1:0] LINE_C   = 128'h01234567_89ABCDEF_FEDCBA98_76543210;
  localparam logic [BLK_BITS-1:0] LINE_D   = 128'hDEADBEEF_CAFEF00D_12345678_9ABCDEF0;
  localparam logic [BLK_BITS-1:0] LINE_E   = 128'h00000000_FFFFFFFF_0F0F0F0F_F0F0F0F0;
  localparam logic [BLK_BITS-1:0] LINE_F   = 128'h5A5A5A5A_A5A5A5A5_3C3C3C3C_C3C3C3C3;

  typedef struct packed {
    cache_req_t req;
    cache_rsp_t rsp;  // expected
  } entry_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  cache_req_t req_i;
  logic       req_ready_o;
  logic       rsp_valid_o;
  cache_rsp_t rsp_o;
  logic       rsp_ready_i;

  entry_t tbl [N_ENTRIES];
  int     n_tbl;
  int     seed;
  int     issue_idx;  // requests accepted so far
  int     rsp_idx;    // responses consumed so far

  cache_mem_top dut0 (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_ready_i ( rsp_ready_i )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  ////////////////////
  // request and response builders
  ////////////////////

  function automatic logic [ADDR_BITS-1:0] line_addr(input logic [TAG_BITS-1:0] tag,
                                                     input logic [IDX_BITS-1:0] idx,
                                                     input logic [OFFS_BITS-1:0] offs);
    return {tag, idx, offs, {BYTE_OFFS_BITS{1'b1}}};  // byte offs must be ignored
  endfunction

  function automatic cache_req_t lookup_req(input logic [TAG_BITS-1:0] tag,
                                            input logic [IDX_BITS-1:0] idx);
    cache_req_t r;
    r      = '0;
    r.op   = OP_LOOKUP;
    r.addr = line_addr(tag, idx, 2'd0);
    return r;
  endfunction

  function automatic cache_req_t write_req(input logic [TAG_BITS-1:0] tag,
                                           input logic [IDX_BITS-1:0] idx,
                                           input logic [OFFS_BITS-1:0] offs,
                                           input logic [XLEN-1:0] wdata,
                                           input logic [BE_BITS-1:0] be);
    cache_req_t r;
    r       = '0;
    r.op    = OP_WRITE;
    r.addr  = line_addr(tag, idx, offs);
    r.wdata = wdata;
    r.be    = be;
    return r;
  endfunction

  function automatic cache_req_t fill_req(input logic [TAG_BITS-1:0] tag,
                                          input logic [IDX_BITS-1:0] idx,
                                          input logic [WAY_BITS-1:0] way,
                                          input logic [BLK_BITS-1:0] line,
                                          input logic dirty);
    cache_req_t r;
    r            = '0;
    r.op         = OP_FILL;
    r.addr       = line_addr(tag, idx, 2'd0);
    r.fill_way   = way;
    r.fill_line  = line;
    r.fill_dirty = dirty;
    return r;
  endfunction

  // state seen by the op before its own update, evict fields zero
  function automatic cache_rsp_t plain_rsp(input cache_op_e op, input logic [WAYS-1:0] ways,
                                           input logic [BLK_BITS-1:0] line, input logic dirty);
    cache_rsp_t r;
    r           = '0;
    r.op        = op;
    r.hit       = |ways;
    r.ways_hit  = ways;
    r.line      = line;
    r.way_dirty = dirty;
    return r;
  endfunction

  // fills in the table never hit on their own tag
  function automatic cache_rsp_t fill_rsp(input logic ev_valid, input logic ev_dirty,
                                          input logic [TAG_BITS-1:0] ev_tag,
                                          input logic [BLK_BITS-1:0] ev_line);
    cache_rsp_t r;
    r             = plain_rsp(OP_FILL, '0, '0, 1'b0);
    r.evict_valid = ev_valid;
    r.evict_dirty = ev_dirty;
    r.evict_tag   = ev_tag;
    r.evict_line  = ev_line;
    return r;
  endfunction

  task automatic add_entry(input cache_req_t req, input cache_rsp_t rsp);
    tbl[n_tbl].req = req;
    tbl[n_tbl].rsp = rsp;
    n_tbl++;
  endtask

  task automatic build_table();
    // empty cache, all misses
    add_entry(lookup_req(TAG_A, 3'd2), plain_rsp(OP_LOOKUP, 2'b00, '0, 1'b0));
    add_entry(lookup_req(TAG_G, 3'd7), plain_rsp(OP_LOOKUP, 2'b00, '0, 1'b0));
    // clean fill into way 1, then hit
    add_entry(fill_req(TAG_A, 3'd2, 1'b1, LINE_A, 1'b0), fill_rsp(1'b0, 1'b0, '0, '0));
    add_entry(lookup_req(TAG_A, 3'd2), plain_rsp(OP_LOOKUP, 2'b10, LINE_A, 1'b0));
    // partial write hit, response shows the line before the merge
    add_entry(write_req(TAG_A, 3'd2, 2'd1, 32'hAABB_CCDD, 4'b0101),
              plain_rsp(OP_WRITE, 2'b10, LINE_A, 1'b0));
    add_entry(lookup_req(TAG_A, 3'd2), plain_rsp(OP_LOOKUP, 2'b10, LINE_A_M, 1'b1));
    // write miss leaves the set alone
    add_entry(write_req(TAG_C, 3'd2, 2'd1, 32'hFFFF_FFFF, 4'b1111),
              plain_rsp(OP_WRITE, 2'b00, '0, 1'b0));
    add_entry(lookup_req(TAG_A, 3'd2), plain_rsp(OP_LOOKUP, 2'b10, LINE_A_M, 1'b1));
    // fill over the dirty line returns the merged victim
    add_entry(fill_req(TAG_B, 3'd2, 1'b1, LINE_B, 1'b0),
              fill_rsp(1'b1, 1'b1, TAG_A, LINE_A_M));
    add_entry(lookup_req(TAG_B, 3'd2), plain_rsp(OP_LOOKUP, 2'b10, LINE_B, 1'b0));
    add_entry(lookup_req(TAG_A, 3'd2), plain_rsp(OP_LOOKUP, 2'b00, '0, 1'b0));
    // more sets, dirty fill into way 0
    add_entry(fill_req(TAG_D, 3'd5, 1'b0, LINE_C, 1'b1), fill_rsp(1'b0, 1'b0, '0, '0));
    add_entry(lookup_req(TAG_D, 3'd5), plain_rsp(OP_LOOKUP, 2'b01, LINE_C, 1'b1));
    add_entry(fill_req(TAG_E, 3'd0, 1'b1, LINE_D, 1'b0), fill_rsp(1'b0, 1'b0, '0, '0));
    add_entry(fill_req(TAG_F, 3'd7, 1'b0, LINE_E, 1'b0), fill_rsp(1'b0, 1'b0, '0, '0));
    // back to back lookups over different sets
    add_entry(lookup_req(TAG_E, 3'd0), plain_rsp(OP_LOOKUP, 2'b10, LINE_D, 1'b0));
    add_entry(lookup_req(TAG_F, 3'd7), plain_rsp(OP_LOOKUP, 2'b01, LINE_E, 1'b0));
    add_entry(lookup_req(TAG_D, 3'd5), plain_rsp(OP_LOOKUP, 2'b01, LINE_C, 1'b1));
    add_entry(lookup_req(TAG_B, 3'd2), plain_rsp(OP_LOOKUP, 2'b10, LINE_B, 1'b0));
    add_entry(lookup_req(TAG_E, 3'd3), plain_rsp(OP_LOOKUP, 2'b00, '0, 1'b0));
    add_entry(lookup_req(TAG_E, 3'd0), plain_rsp(OP_LOOKUP, 2'b10, LINE_D, 1'b0));
    add_entry(lookup_req(TAG_G, 3'd7), plain_rsp(OP_LOOKUP, 2'b00, '0, 1'b0));
    // both ways of set 2 valid
    add_entry(fill_req(TAG_G, 3'd2, 1'b0, LINE_F, 1'b0), fill_rsp(1'b0, 1'b0, '0, '0));
    add_entry(lookup_req(TAG_G, 3'd2), plain_rsp(OP_LOOKUP, 2'b01, LINE_F, 1'b0));
    add_entry(lookup_req(TAG_B, 3'd2), plain_rsp(OP_LOOKUP, 2'b10, LINE_B, 1'b0));
  endtask

  ////////////////////
  // checking
  ////////////////////

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_value(input int idx, input string what);
    $display("Fail at %0t: entry %0d %s", $time, idx, what);
    stop_run();
  endtask

  task automatic check_flags(input int idx, input cache_rsp_t got, input cache_rsp_t exp);
    if (got.op !== exp.op)
      report_value(idx, $sformatf("op %0d, expected %0d", got.op, exp.op));
    if (got.hit !== exp.hit)
      report_value(idx, $sformatf("hit %0b, expected %0b", got.hit, exp.hit));
    if (got.ways_hit !== exp.ways_hit)
      report_value(idx, $sformatf("ways_hit %b, expected %b", got.ways_hit, exp.ways_hit));
    if (got.way_dirty !== exp.way_dirty)
      report_value(idx, $sformatf("way_dirty %0b, expected %0b", got.way_dirty, exp.way_dirty));
  endtask

  task automatic check_line(input int idx, input cache_rsp_t got, input cache_rsp_t exp);
    if (got.line !== exp.line)
      report_value(idx, $sformatf("line %h, expected %h", got.line, exp.line));
  endtask

  // victim tag and line only defined for a valid victim
  task automatic check_evict(input int idx, input cache_rsp_t got, input cache_rsp_t exp);
    if (got.evict_valid !== exp.evict_valid)
      report_value(idx, $sformatf("evict_valid %0b, expected %0b",
                                  got.evict_valid, exp.evict_valid));
    if (got.evict_dirty !== exp.evict_dirty)
      report_value(idx, $sformatf("evict_dirty %0b, expected %0b",
                                  got.evict_dirty, exp.evict_dirty));
    if (exp.evict_valid && (got.evict_tag !== exp.evict_tag))
      report_value(idx, $sformatf("evict_tag %h, expected %h", got.evict_tag, exp.evict_tag));
    if (exp.evict_valid && (got.evict_line !== exp.evict_line))
      report_value(idx, $sformatf("evict_line %h, expected %h",
                                  got.evict_line, exp.evict_line));
  endtask

  ////////////////////
  // stimulus and monitor
  ////////////////////

  initial
  begin
    seed        = SEED_INIT;
    n_tbl       = 0;
    issue_idx   = 0;
    rsp_idx     = 0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    build_table();
    if (n_tbl != N_ENTRIES)
    begin
      $display("stimulus table holds %0d entries instead of %0d", n_tbl, N_ENTRIES);
      stop_run();
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    while (rsp_idx < N_ENTRIES)
    begin
      @(negedge clk_i);
      rsp_ready_i = (($random(seed) % 4) != 0);  // ready about 3 cycles of 4
      if (issue_idx < N_ENTRIES)
      begin
        req_valid_i = 1'b1;
        req_i       = tbl[issue_idx].req;  // held until accepted
      end
      else
      begin
        req_valid_i = 1'b0;
        req_i       = '0;
      end
      #(CLK_PERIOD/4);  // mid low phase, DUT outputs settled
      if (rsp_valid_o && rsp_ready_i)
      begin
        if (rsp_idx >= issue_idx)
        begin
          $display("response arrived with no request outstanding");
          stop_run();
        end
        check_flags(rsp_idx, rsp_o, tbl[rsp_idx].rsp);
        check_line(rsp_idx, rsp_o, tbl[rsp_idx].rsp);
        check_evict(rsp_idx, rsp_o, tbl[rsp_idx].rsp);
        rsp_idx++;
      end
      if (req_valid_i && req_ready_o)
        issue_idx++;
    end

    // pipe drains in three stages, nothing more may come out
    repeat (4)
    begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
      rsp_ready_i = 1'b1;
      #(CLK_PERIOD/4);
      if (rsp_valid_o)
      begin
        $display("extra response after the last table entry");
        stop_run();
      end
    end
    $display("TB PASSED");
    $finish;
  end

  // watchdog, 20 cycles per table entry
  initial
  begin
    #(N_ENTRIES * 20 * CLK_PERIOD);
    $display("timeout with %0d of %0d responses received", rsp_idx, N_ENTRIES);
    stop_run();
  end

endmodule

`default_nettype wire

// ==== design/cache_mem_top.sv ====
// cache memory top level
// joins decode, execute and result stages
// one stall line freezes the whole pipe under response back-pressure

`default_nettype none

module cache_mem_top
  import cache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_valid_i,
  input  cache_req_t req_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output cache_rsp_t rsp_o,
  input  logic       rsp_ready_i
);

  logic                          stall;         // response waiting
  logic                          dec_valid;
  cache_dec_t                    dec;
  logic                          exe_valid;
  cache_op_e                     exe_op;
  logic [WAYS-1:0]               ways_hit;
  logic [WAYS-1:0][BLK_BITS-1:0] way_lines;
  logic                          way_dirty;
  logic                          evict_valid;
  logic                          evict_dirty;
  logic [TAG_BITS-1:0]           evict_tag;
  logic [WAY_BITS-1:0]           exe_fill_way;  // fill way of execute stage

  assign stall       = rsp_valid_o & ~rsp_ready_i;
  assign req_ready_o = ~stall;

  cache_decode u_decode (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .stall_i     ( stall       ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .dec_valid_o ( dec_valid   ),
    .dec_o       ( dec         )
  );

  cache_arrays u_arrays (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .stall_i        ( stall        ),
    .dec_valid_i    ( dec_valid    ),
    .dec_i          ( dec          ),
    .exe_valid_o    ( exe_valid    ),
    .exe_op_o       ( exe_op       ),
    .ways_hit_o     ( ways_hit     ),
    .way_lines_o    ( way_lines    ),
    .way_dirty_o    ( way_dirty    ),
    .evict_valid_o  ( evict_valid  ),
    .evict_dirty_o  ( evict_dirty  ),
    .evict_tag_o    ( evict_tag    ),
    .exe_fill_way_o ( exe_fill_way )
  );

  cache_result u_result (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .stall_i       ( stall        ),
    .exe_valid_i   ( exe_valid    ),
    .exe_op_i      ( exe_op       ),
    .ways_hit_i    ( ways_hit     ),
    .way_lines_i   ( way_lines    ),
    .way_dirty_i   ( way_dirty    ),
    .evict_valid_i ( evict_valid  ),
    .evict_dirty_i ( evict_dirty  ),
    .evict_tag_i   ( evict_tag    ),
    .fill_way_i    ( exe_fill_way ),
    .rsp_valid_o   ( rsp_valid_o  ),
    .rsp_o         ( rsp_o        )
  );

endmodule

`default_nettype wire

// ==== design/cache_result.sv ====
// cache result stage
// and-or mux of the hit way line, victim line select for fills
// and the response register held under back-pressure

`default_nettype none

module cache_result
  import cache_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           stall_i,
  input  logic                           exe_valid_i,
  input  cache_op_e                      exe_op_i,
  input  logic [WAYS-1:0]                ways_hit_i,
  input  logic [WAYS-1:0][BLK_BITS-1:0]  way_lines_i,
  input  logic                           way_dirty_i,
  input  logic                           evict_valid_i,
  input  logic                           evict_dirty_i,
  input  logic [TAG_BITS-1:0]            evict_tag_i,
  input  logic [WAY_BITS-1:0]            fill_way_i,
  output logic                           rsp_valid_o,
  output cache_rsp_t                     rsp_o
);

  logic                is_fill;
  logic [BLK_BITS-1:0] line_sel;  // hit way line
  cache_rsp_t          rsp_d;

  assign is_fill = (exe_op_i == OP_FILL);

  // and-or mux, zero on miss
  always_comb
  begin
    line_sel = '0;
    for (int w = 0; w < WAYS; w++)
      line_sel = line_sel | (way_lines_i[w] & {BLK_BITS{ways_hit_i[w]}});
  end

  ////////////////////
  // response build
  ////////////////////

  always_comb
  begin
    rsp_d.op          = exe_op_i;
    rsp_d.hit         = |ways_hit_i;
    rsp_d.ways_hit    = ways_hit_i;
    rsp_d.line        = line_sel;
    rsp_d.way_dirty   = way_dirty_i;
    // evict fields only carry data for a fill
    rsp_d.evict_valid = is_fill & evict_valid_i;
    rsp_d.evict_dirty = is_fill & evict_dirty_i;
    rsp_d.evict_tag   = is_fill ? evict_tag_i : '0;
    rsp_d.evict_line  = is_fill ? way_lines_i[fill_way_i] : '0;  // old line, read-first
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rsp_valid_o <= 1'b0;
    else if (!stall_i)
      rsp_valid_o <= exe_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
      rsp_o <= rsp_d;  // held while waiting for consumer
  end

  // pending response must not move until consumed
  a_rsp_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    stall_i |=> (rsp_valid_o && $stable(rsp_o))
  );

endmodule

`default_nettype wire

// ==== design/cache_arrays.sv ====
// cache execute stage
// tag, valid and dirty flip-flops with per-way tag compare
// byte-enable data array with read-first synchronous read
// captures the victim state of a fill before it is replaced

`default_nettype none

module cache_arrays
  import cache_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           stall_i,
  input  logic                           dec_valid_i,
  input  cache_dec_t                     dec_i,
  output logic                           exe_valid_o,
  output cache_op_e                      exe_op_o,
  output logic [WAYS-1:0]                ways_hit_o,
  output logic [WAYS-1:0][BLK_BITS-1:0]  way_lines_o,
  output logic                           way_dirty_o,
  output logic                           evict_valid_o,
  output logic                           evict_dirty_o,
  output logic [TAG_BITS-1:0]            evict_tag_o,
  output logic [WAY_BITS-1:0]            exe_fill_way_o
);

  logic                               advance;     // execute cycle ends this edge
  logic                               is_write;
  logic                               is_fill;
  logic [WAYS-1:0]                    way_hit;     // compare result
  logic [WAYS-1:0]                    fill_sel;    // fill into this way
  logic [WAYS-1:0]                    wr_sel;      // write hit in this way
  logic [WAYS-1:0]                    cur_valid;   // state at dec_i.idx
  logic [WAYS-1:0]                    cur_dirty;
  logic [WAYS-1:0][TAG_BITS-1:0]      cur_tag;
  logic [LINE_BE_BITS-1:0]            dat_be;
  logic [BLK_BITS-1:0]                dat_in;

  assign advance  = dec_valid_i & ~stall_i;          // no writes while frozen
  assign is_write = (dec_i.op == OP_WRITE);
  assign is_fill  = (dec_i.op == OP_FILL);

  ////////////////////
  // write data path
  ////////////////////

  always_comb
  begin
    if (is_fill)
    begin
      dat_be = '1;                                   // whole line
      dat_in = dec_i.fill_line;
    end
    else
    begin
      dat_be = '0;
      dat_be[dec_i.offs*BE_BITS +: BE_BITS] = dec_i.be;  // word slot only
      dat_in = {(BLK_BITS/XLEN){dec_i.wdata}};           // replicate word
    end
  end

  ////////////////////
  // per-way storage
  ////////////////////

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    logic [TAG_BITS-1:0] tag_q [SETS];
    logic [SETS-1:0]     valid_q;
    logic [SETS-1:0]     dirty_q;
    logic [BLK_BITS-1:0] mem   [SETS];
    logic [BLK_BITS-1:0] rd_q;                       // read port register

    assign cur_valid[w] = valid_q[dec_i.idx];
    assign cur_dirty[w] = valid_q[dec_i.idx] & dirty_q[dec_i.idx];
    assign cur_tag[w]   = tag_q[dec_i.idx];
    assign way_hit[w]   = cur_valid[w] & (cur_tag[w] == dec_i.tag);

    assign fill_sel[w] = advance & is_fill & (int'(dec_i.fill_way) == w);
    assign wr_sel[w]   = advance & is_write & way_hit[w];  // miss writes nothing

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q <= '0;
        dirty_q <= '0;
      end
      else if (fill_sel[w])
      begin
        valid_q[dec_i.idx] <= 1'b1;
        dirty_q[dec_i.idx] <= dec_i.fill_dirty;
      end
      else if (wr_sel[w])
        dirty_q[dec_i.idx] <= 1'b1;                  // written line is dirty
    end

    always_ff @(posedge clk_i)
    begin
      if (fill_sel[w])
        tag_q[dec_i.idx] <= dec_i.tag;
    end

    // read and write share the edge, read sees old contents
    always_ff @(posedge clk_i)
    begin
      for (int b = 0; b < LINE_BE_BITS; b++)
      begin
        if ((fill_sel[w] | wr_sel[w]) & dat_be[b])
          mem[dec_i.idx][b*8 +: 8] <= dat_in[b*8 +: 8];
      end
      if (!stall_i)
        rd_q <= mem[dec_i.idx];
    end

    assign way_lines_o[w] = rd_q;
  end

  ////////////////////
  // stage register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      exe_valid_o <= 1'b0;
    else if (!stall_i)
      exe_valid_o <= dec_valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      exe_op_o       <= dec_i.op;
      ways_hit_o     <= way_hit;
      way_dirty_o    <= |(way_hit & cur_dirty);      // dirty of the hit way
      evict_valid_o  <= cur_valid[dec_i.fill_way];   // victim before overwrite
      evict_dirty_o  <= cur_dirty[dec_i.fill_way];
      evict_tag_o    <= cur_tag[dec_i.fill_way];
      exe_fill_way_o <= dec_i.fill_way;
    end
  end

  // one tag per set at most, kept by the fill path over time
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dec_valid_i |-> $onehot0(way_hit)
  );

  // fill must name a known, existing way
  a_fill_way_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (dec_valid_i && is_fill) |->
      (!$isunknown(dec_i.fill_way) && (int'(dec_i.fill_way) < WAYS))
  );

endmodule

`default_nettype wire

// ==== design/cache_decode.sv ====
// cache decode stage
// registers each accepted request and splits the address
// into tag, set index and word offset

`default_nettype none

module cache_decode
  import cache_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       stall_i,
  input  logic       req_valid_i,
  input  cache_req_t req_i,
  output logic       dec_valid_o,
  output cache_dec_t dec_o
);

  cache_dec_t dec_d;  // split fields, next value

  ////////////////////
  // address split
  ////////////////////

  always_comb
  begin
    dec_d.op         = req_i.op;
    dec_d.tag        = req_i.addr[ADDR_BITS-1 -: TAG_BITS];           // upper bits
    dec_d.idx        = req_i.addr[BYTE_OFFS_BITS+OFFS_BITS +: IDX_BITS];
    dec_d.offs       = req_i.addr[BYTE_OFFS_BITS +: OFFS_BITS];       // byte offs dropped
    dec_d.wdata      = req_i.wdata;
    dec_d.be         = req_i.be;
    dec_d.fill_line  = req_i.fill_line;
    dec_d.fill_way   = req_i.fill_way;
    dec_d.fill_dirty = req_i.fill_dirty;
  end

  ////////////////////
  // stage register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dec_valid_o <= 1'b0;
    else if (!stall_i)
      dec_valid_o <= req_valid_i;  // bubble when no request
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
      dec_o <= dec_d;  // hold under stall
  end

  // accepted request must carry a legal opcode
  a_req_op_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !stall_i) |->
      (!$isunknown(req_i.op) && (req_i.op inside {OP_LOOKUP, OP_WRITE, OP_FILL}))
  );

endmodule

`default_nettype wire

// ==== design/cache_pkg.sv ====
// cache memory block package
// sizes, opcode enum and the request, decoded and response structs
// shared by the decode, execute and result stages

`default_nettype none

package cache_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int XLEN           = 32;   // word width
  localparam int ADDR_BITS      = 16;   // physical address
  localparam int WAYS           = 2;
  localparam int SETS           = 8;
  localparam int BLK_BITS       = 128;  // four words per line
  localparam int IDX_BITS       = 3;
  localparam int OFFS_BITS      = 2;    // word within line
  localparam int BYTE_OFFS_BITS = 2;    // byte within word
  localparam int TAG_BITS       = ADDR_BITS - IDX_BITS - OFFS_BITS - BYTE_OFFS_BITS;
  localparam int WAY_BITS       = 1;

  localparam int BE_BITS        = XLEN / 8;      // byte enables per word
  localparam int LINE_BE_BITS   = BLK_BITS / 8;  // byte enables per line

  ////////////////////
  // opcodes
  ////////////////////

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,  // hit check and line read
    OP_WRITE  = 2'd1,  // word merge on hit
    OP_FILL   = 2'd2   // line install into named way
  } cache_op_e;

  ////////////////////
  // structs
  ////////////////////

  // request from core side
  typedef struct packed {
    cache_op_e             op;
    logic [ADDR_BITS-1:0]  addr;
    logic [XLEN-1:0]       wdata;
    logic [BE_BITS-1:0]    be;
    logic [BLK_BITS-1:0]   fill_line;
    logic [WAY_BITS-1:0]   fill_way;
    logic                  fill_dirty;
  } cache_req_t;

  // request after address split
  typedef struct packed {
    cache_op_e             op;
    logic [TAG_BITS-1:0]   tag;
    logic [IDX_BITS-1:0]   idx;
    logic [OFFS_BITS-1:0]  offs;
    logic [XLEN-1:0]       wdata;
    logic [BE_BITS-1:0]    be;
    logic [BLK_BITS-1:0]   fill_line;
    logic [WAY_BITS-1:0]   fill_way;
    logic                  fill_dirty;
  } cache_dec_t;

  // one response per request, in order
  typedef struct packed {
    cache_op_e             op;
    logic                  hit;
    logic [WAYS-1:0]       ways_hit;
    logic [BLK_BITS-1:0]   line;         // hit way line
    logic                  way_dirty;    // hit way dirty
    logic                  evict_valid;  // fill only
    logic                  evict_dirty;
    logic [TAG_BITS-1:0]   evict_tag;
    logic [BLK_BITS-1:0]   evict_line;
  } cache_rsp_t;

endpackage

`default_nettype wire
